//--- src/dtm_pkg.sv
package dtm_pkg;

    localparam int IR_BITS = 5;

    // standard 16-state TAP, encoding follows the usual 0..F order
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'h0,
        RUN_TEST_IDLE    = 4'h1,
        SELECT_DR        = 4'h2,
        CAPTURE_DR       = 4'h3,
        SHIFT_DR         = 4'h4,
        EXIT1_DR         = 4'h5,
        PAUSE_DR         = 4'h6,
        EXIT2_DR         = 4'h7,
        UPDATE_DR        = 4'h8,
        SELECT_IR        = 4'h9,
        CAPTURE_IR       = 4'hA,
        SHIFT_IR         = 4'hB,
        EXIT1_IR         = 4'hC,
        PAUSE_IR         = 4'hD,
        EXIT2_IR         = 4'hE,
        UPDATE_IR        = 4'hF
    } tap_state_e;

    typedef enum logic [IR_BITS-1:0] {
        IR_IDCODE = 5'b00001,
        IR_DTMCS  = 5'b10000,
        IR_DMI    = 5'b10001,
        IR_BYPASS = 5'b11111
    } ir_code_e;

    // version 1, part e200, manufacturer 537, fixed one
    localparam logic [31:0] IDCODE_VALUE  = 32'h1e20_0a6f;
    localparam logic [3:0]  DTM_VERSION   = 4'h1;
    localparam logic [2:0]  DTM_IDLE_HINT = 3'h5;

endpackage

//--- src/dmi_pkg.sv
package dmi_pkg;

    localparam int DMI_ADDR_BITS = 6;   // default, top level may override
    localparam int DMI_DATA_BITS = 32;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } dmi_op_e;

    typedef enum logic [1:0] {
        RESP_OK   = 2'd0,
        RESP_BUSY = 2'd3
    } dmi_resp_e;

    // same bit order as the DMI shift register
    typedef struct packed {
        logic [DMI_ADDR_BITS-1:0] addr;
        logic [DMI_DATA_BITS-1:0] data;
        dmi_op_e                  op;
    } dmi_req_t;

    typedef struct packed {
        logic [DMI_ADDR_BITS-1:0] addr;
        logic [DMI_DATA_BITS-1:0] data;
        dmi_resp_e                resp;
    } dmi_resp_t;

endpackage

//--- src/jtag_tap_ctrl.sv
`timescale 1ns/1ps

module jtag_tap_ctrl (
    input  logic                             rst_n,
    input  logic                             jtag_TCK,
    input  logic                             tms_i,
    output dtm_pkg::tap_state_e              tap_state_o,
    input  logic [dtm_pkg::IR_BITS-1:0]      ir_code_i,
    output dtm_pkg::ir_code_e                ir_code_o
);

    dtm_pkg::tap_state_e state_q;
    dtm_pkg::tap_state_e state_d;

    assign tap_state_o = state_q;

    always_comb begin
        case (state_q)
            dtm_pkg::TEST_LOGIC_RESET: state_d = tms_i ? dtm_pkg::TEST_LOGIC_RESET
                                                       : dtm_pkg::RUN_TEST_IDLE;
            dtm_pkg::RUN_TEST_IDLE:    state_d = tms_i ? dtm_pkg::SELECT_DR
                                                       : dtm_pkg::RUN_TEST_IDLE;
            dtm_pkg::SELECT_DR:        state_d = tms_i ? dtm_pkg::SELECT_IR
                                                       : dtm_pkg::CAPTURE_DR;
            dtm_pkg::CAPTURE_DR:       state_d = tms_i ? dtm_pkg::EXIT1_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::SHIFT_DR:         state_d = tms_i ? dtm_pkg::EXIT1_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::EXIT1_DR:         state_d = tms_i ? dtm_pkg::UPDATE_DR : dtm_pkg::PAUSE_DR;
            dtm_pkg::PAUSE_DR:         state_d = tms_i ? dtm_pkg::EXIT2_DR : dtm_pkg::PAUSE_DR;
            dtm_pkg::EXIT2_DR:         state_d = tms_i ? dtm_pkg::UPDATE_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::UPDATE_DR:        state_d = tms_i ? dtm_pkg::SELECT_DR
                                                       : dtm_pkg::RUN_TEST_IDLE;
            dtm_pkg::SELECT_IR:        state_d = tms_i ? dtm_pkg::TEST_LOGIC_RESET
                                                       : dtm_pkg::CAPTURE_IR;
            dtm_pkg::CAPTURE_IR:       state_d = tms_i ? dtm_pkg::EXIT1_IR : dtm_pkg::SHIFT_IR;
            dtm_pkg::SHIFT_IR:         state_d = tms_i ? dtm_pkg::EXIT1_IR : dtm_pkg::SHIFT_IR;
            dtm_pkg::EXIT1_IR:         state_d = tms_i ? dtm_pkg::UPDATE_IR : dtm_pkg::PAUSE_IR;
            dtm_pkg::PAUSE_IR:         state_d = tms_i ? dtm_pkg::EXIT2_IR : dtm_pkg::PAUSE_IR;
            dtm_pkg::EXIT2_IR:         state_d = tms_i ? dtm_pkg::UPDATE_IR : dtm_pkg::SHIFT_IR;
            default:                   state_d = tms_i ? dtm_pkg::SELECT_DR    // UPDATE_IR
                                                       : dtm_pkg::RUN_TEST_IDLE;
        endcase
    end

    always_ff @(posedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dtm_pkg::TEST_LOGIC_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // IR changes on the falling edge, half a cycle after the shift settles
    always_ff @(negedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            ir_code_o <= dtm_pkg::IR_IDCODE;
        end else if (state_q == dtm_pkg::TEST_LOGIC_RESET) begin
            ir_code_o <= dtm_pkg::IR_IDCODE;
        end else if (state_q == dtm_pkg::UPDATE_IR) begin
            ir_code_o <= dtm_pkg::ir_code_e'(ir_code_i);
        end
    end

endmodule

//--- src/jtag_dtm.sv
`timescale 1ns/1ps

module jtag_dtm #(
    parameter int DMI_ADDR_BITS = 6
) (
    input  logic                          rst_n,
    input  logic                          jtag_TCK,
    input  logic                          tdi_i,
    output logic                          tdo_o,
    input  dtm_pkg::tap_state_e           tap_state_i,
    input  dtm_pkg::ir_code_e             ir_code_i,
    output logic [dtm_pkg::IR_BITS-1:0]   ir_shift_o,
    output logic                          req_start_o,
    output dmi_pkg::dmi_req_t             req_o,
    input  logic                          tx_idle_i,
    input  logic                          resp_strobe_i,
    input  dmi_pkg::dmi_resp_t            resp_i
);

    localparam int SHIFT_BITS = $bits(dmi_pkg::dmi_req_t);
    localparam int WORD_BITS  = dmi_pkg::DMI_DATA_BITS;
    localparam int IR_BITS    = dtm_pkg::IR_BITS;

    localparam dmi_pkg::dmi_resp_t BUSY_RESP = '{
        addr: '0,
        data: '0,
        resp: dmi_pkg::RESP_BUSY
    };

    logic [SHIFT_BITS-1:0] shift_q;
    dmi_pkg::dmi_resp_t    resp_q;      // last response from the target
    logic                  dmi_busy_q;  // request in flight
    logic                  sticky_q;
    logic                  busy;
    logic [1:0]            dmistat;
    logic [31:0]           dtmcs;
    logic                  dmireset;

    assign busy     = dmi_busy_q | sticky_q;
    assign dmistat  = busy ? 2'b01 : 2'b00;
    assign dmireset = shift_q[16];
    assign dtmcs    = {14'b0,
                       1'b0,                     // dmihardreset
                       1'b0,                     // dmireset reads as 0
                       1'b0,
                       dtm_pkg::DTM_IDLE_HINT,
                       dmistat,
                       6'(DMI_ADDR_BITS),        // abits
                       dtm_pkg::DTM_VERSION};

    assign ir_shift_o = shift_q[IR_BITS-1:0];

    // capture and shift, everything goes out through bit 0
    always_ff @(posedge jtag_TCK) begin
        case (tap_state_i)
            dtm_pkg::CAPTURE_IR: shift_q <= {{(SHIFT_BITS-2){1'b0}}, 2'b01};
            dtm_pkg::SHIFT_IR:
                shift_q <= {{(SHIFT_BITS-IR_BITS){1'b0}}, tdi_i, shift_q[IR_BITS-1:1]};
            dtm_pkg::CAPTURE_DR: begin
                case (ir_code_i)
                    dtm_pkg::IR_IDCODE:
                        shift_q <= {{(SHIFT_BITS-WORD_BITS){1'b0}}, dtm_pkg::IDCODE_VALUE};
                    dtm_pkg::IR_DTMCS:
                        shift_q <= {{(SHIFT_BITS-WORD_BITS){1'b0}}, dtmcs};
                    dtm_pkg::IR_DMI:
                        shift_q <= busy ? BUSY_RESP : resp_q;
                    default: shift_q <= '0;     // bypass
                endcase
            end
            dtm_pkg::SHIFT_DR: begin
                case (ir_code_i)
                    dtm_pkg::IR_IDCODE, dtm_pkg::IR_DTMCS:
                        shift_q <= {{(SHIFT_BITS-WORD_BITS){1'b0}}, tdi_i,
                                    shift_q[WORD_BITS-1:1]};
                    dtm_pkg::IR_DMI:
                        shift_q <= {tdi_i, shift_q[SHIFT_BITS-1:1]};
                    default: shift_q <= {{(SHIFT_BITS-1){1'b0}}, tdi_i};  // one bit delay
                endcase
            end
            default: ;
        endcase
    end

    // request pulse in the cycle after UPDATE_DR
    always_ff @(posedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            req_start_o <= 1'b0;
        end else begin
            req_start_o <= (tap_state_i == dtm_pkg::UPDATE_DR) &&
                           (ir_code_i == dtm_pkg::IR_DMI) && !busy && tx_idle_i;
        end
    end

    always_ff @(posedge jtag_TCK) begin
        if (tap_state_i == dtm_pkg::UPDATE_DR) begin
            req_o <= shift_q;
        end
    end

    always_ff @(posedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            dmi_busy_q <= 1'b0;
            resp_q     <= '0;
        end else if (req_start_o) begin
            dmi_busy_q <= 1'b1;
        end else if (resp_strobe_i) begin
            dmi_busy_q <= 1'b0;
            resp_q     <= resp_i;
        end
    end

    // sticky busy, only dmireset clears it
    always_ff @(posedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            sticky_q <= 1'b0;
        end else if (tap_state_i == dtm_pkg::CAPTURE_DR && ir_code_i == dtm_pkg::IR_DMI) begin
            if (busy) sticky_q <= 1'b1;
        end else if (tap_state_i == dtm_pkg::UPDATE_DR && ir_code_i == dtm_pkg::IR_DTMCS) begin
            if (dmireset) sticky_q <= 1'b0;
        end
    end

    always_ff @(negedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            tdo_o <= 1'b0;
        end else if (tap_state_i == dtm_pkg::SHIFT_IR || tap_state_i == dtm_pkg::SHIFT_DR) begin
            tdo_o <= shift_q[0];
        end else begin
            tdo_o <= 1'b0;
        end
    end

endmodule

//--- src/dmi_req_tx.sv
`timescale 1ns/1ps

module dmi_req_tx (
    input  logic              rst_n,
    input  logic              jtag_TCK,
    input  logic              start_i,
    input  dmi_pkg::dmi_req_t req_i,
    input  logic              ack_i,
    output logic              valid_o,
    output dmi_pkg::dmi_req_t req_o,
    output logic              idle_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_WAIT_ACK,
        TX_WAIT_DROP    // valid low, ack still high
    } tx_state_e;

    tx_state_e state_q;

    assign idle_o = (state_q == TX_IDLE);

    always_ff @(posedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= TX_IDLE;
            valid_o <= 1'b0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (start_i) begin
                        valid_o <= 1'b1;
                        state_q <= TX_WAIT_ACK;
                    end
                end
                TX_WAIT_ACK: begin
                    if (ack_i) begin
                        valid_o <= 1'b0;
                        state_q <= TX_WAIT_DROP;
                    end
                end
                default: if (!ack_i) state_q <= TX_IDLE;
            endcase
        end
    end

    // held stable while valid is up
    always_ff @(posedge jtag_TCK) begin
        if (state_q == TX_IDLE && start_i) begin
            req_o <= req_i;
        end
    end

endmodule

//--- src/dmi_resp_rx.sv
`timescale 1ns/1ps

module dmi_resp_rx (
    input  logic               rst_n,
    input  logic               jtag_TCK,
    input  logic               valid_i,
    input  dmi_pkg::dmi_resp_t resp_i,
    output logic               ack_o,
    output logic               strobe_o,
    output dmi_pkg::dmi_resp_t resp_o
);

    logic new_valid;

    // valid up while ack still low means a fresh transfer
    assign new_valid = valid_i && !ack_o;

    always_ff @(posedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            ack_o    <= 1'b0;
            strobe_o <= 1'b0;
        end else begin
            strobe_o <= new_valid;
            if (new_valid) begin
                ack_o <= 1'b1;
            end else if (!valid_i) begin
                ack_o <= 1'b0;      // sender let go
            end
        end
    end

    always_ff @(posedge jtag_TCK) begin
        if (new_valid) resp_o <= resp_i;
    end

endmodule

//--- src/dmi_regfile.sv
`timescale 1ns/1ps

module dmi_regfile #(
    parameter int DMI_ADDR_BITS = 6,
    parameter int REG_COUNT     = 16
) (
    input  logic               rst_n,
    input  logic               jtag_TCK,
    input  logic               req_valid_i,
    input  dmi_pkg::dmi_req_t  req_i,
    output logic               req_ack_o,
    output logic               resp_valid_o,
    output dmi_pkg::dmi_resp_t resp_o,
    input  logic               resp_ack_i
);

    localparam int IDX_BITS = $clog2(REG_COUNT);

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_REQ_DROP,    // wait for valid low
        RF_RESP,
        RF_RESP_DROP    // wait for resp ack low
    } rf_state_e;

    rf_state_e                          state_q;
    logic [dmi_pkg::DMI_DATA_BITS-1:0]  regs_q [REG_COUNT];
    logic [DMI_ADDR_BITS-1:0]           req_addr;
    logic [IDX_BITS-1:0]                idx;
    logic                               in_range;
    logic [dmi_pkg::DMI_DATA_BITS-1:0]  rdata;
    logic                               accept;

    assign req_addr = req_i.addr;
    assign idx      = req_addr[IDX_BITS-1:0];
    assign in_range = int'(req_addr) < REG_COUNT;
    assign accept   = (state_q == RF_IDLE) && req_valid_i;

    always_comb begin
        case (req_i.op)
            dmi_pkg::OP_READ:  rdata = in_range ? regs_q[idx] : '0;
            dmi_pkg::OP_WRITE: rdata = in_range ? req_i.data : '0;  // value as stored
            default:           rdata = '0;
        endcase
    end

    always_ff @(posedge jtag_TCK or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= RF_IDLE;
            req_ack_o    <= 1'b0;
            resp_valid_o <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) regs_q[i] <= '0;
        end else begin
            case (state_q)
                RF_IDLE: begin
                    if (req_valid_i) begin
                        req_ack_o <= 1'b1;
                        state_q   <= RF_REQ_DROP;
                        if (req_i.op == dmi_pkg::OP_WRITE && in_range) regs_q[idx] <= req_i.data;
                    end
                end
                RF_REQ_DROP: begin
                    if (!req_valid_i) begin
                        req_ack_o    <= 1'b0;
                        resp_valid_o <= 1'b1;
                        state_q      <= RF_RESP;
                    end
                end
                RF_RESP: begin
                    if (resp_ack_i) begin
                        resp_valid_o <= 1'b0;
                        state_q      <= RF_RESP_DROP;
                    end
                end
                default: if (!resp_ack_i) state_q <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge jtag_TCK) begin
        if (accept) begin
            resp_o <= '{addr: req_i.addr, data: rdata, resp: dmi_pkg::RESP_OK};
        end
    end

endmodule

//--- src/jtag_dtm_top.sv
`timescale 1ns/1ps

module jtag_dtm_top #(
    parameter int DMI_ADDR_BITS = 6,
    parameter int REG_COUNT     = 16
) (
    input  logic rst_n,
    input  logic jtag_TCK,
    input  logic jtag_tms_i,
    input  logic jtag_tdi_i,
    output logic jtag_tdo_o
);

    dtm_pkg::tap_state_e           tap_state;
    dtm_pkg::ir_code_e             ir_code;
    logic [dtm_pkg::IR_BITS-1:0]   ir_shift;
    logic                          req_start;
    dmi_pkg::dmi_req_t             req_data;     // from the DTM
    logic                          tx_idle;
    logic                          req_valid;
    dmi_pkg::dmi_req_t             req_bus;      // held by the sender
    logic                          req_ack;
    logic                          resp_valid;
    dmi_pkg::dmi_resp_t            resp_bus;
    logic                          resp_ack;
    logic                          resp_strobe;
    dmi_pkg::dmi_resp_t            resp_data;

    jtag_tap_ctrl jtag_tap_ctrl_inst (
        .rst_n       (rst_n),
        .jtag_TCK    (jtag_TCK),
        .tms_i       (jtag_tms_i),
        .tap_state_o (tap_state),
        .ir_code_i   (ir_shift),
        .ir_code_o   (ir_code)
    );

    jtag_dtm #(
        .DMI_ADDR_BITS (DMI_ADDR_BITS)
    ) jtag_dtm_inst (
        .rst_n         (rst_n),
        .jtag_TCK      (jtag_TCK),
        .tdi_i         (jtag_tdi_i),
        .tdo_o         (jtag_tdo_o),
        .tap_state_i   (tap_state),
        .ir_code_i     (ir_code),
        .ir_shift_o    (ir_shift),
        .req_start_o   (req_start),
        .req_o         (req_data),
        .tx_idle_i     (tx_idle),
        .resp_strobe_i (resp_strobe),
        .resp_i        (resp_data)
    );

    dmi_req_tx dmi_req_tx_inst (
        .rst_n    (rst_n),
        .jtag_TCK (jtag_TCK),
        .start_i  (req_start),
        .req_i    (req_data),
        .ack_i    (req_ack),
        .valid_o  (req_valid),
        .req_o    (req_bus),
        .idle_o   (tx_idle)
    );

    dmi_regfile #(
        .DMI_ADDR_BITS (DMI_ADDR_BITS),
        .REG_COUNT     (REG_COUNT)
    ) dmi_regfile_inst (
        .rst_n        (rst_n),
        .jtag_TCK     (jtag_TCK),
        .req_valid_i  (req_valid),
        .req_i        (req_bus),
        .req_ack_o    (req_ack),
        .resp_valid_o (resp_valid),
        .resp_o       (resp_bus),
        .resp_ack_i   (resp_ack)
    );

    dmi_resp_rx dmi_resp_rx_inst (
        .rst_n    (rst_n),
        .jtag_TCK (jtag_TCK),
        .valid_i  (resp_valid),
        .resp_i   (resp_bus),
        .ack_o    (resp_ack),
        .strobe_o (resp_strobe),
        .resp_o   (resp_data)
    );

endmodule

//--- dv/tb_jtag_dtm_top.sv
`timescale 1ns/1ps

module tb_jtag_dtm_top;

    localparam int REG_COUNT      = 16;
    localparam int ADDR_BITS      = 6;
    localparam int TIMEOUT_CYCLES = 20000;  // roughly 3x the full sequence

    localparam logic [4:0] IR_DTMCS  = 5'b10000;
    localparam logic [4:0] IR_DMI    = 5'b10001;
    localparam logic [4:0] IR_BYPASS = 5'b11111;

    localparam logic [1:0]  OP_NOP    = 2'd0;
    localparam logic [1:0]  OP_READ   = 2'd1;
    localparam logic [1:0]  OP_WRITE  = 2'd2;
    localparam logic [1:0]  RESP_OK   = 2'd0;
    localparam logic [39:0] BUSY_WORD = 40'h3;  // zero addr and data, busy code

    logic jtag_TCK = 1'b0;
    logic rst_n;
    logic tms;
    logic tdi;
    logic tdo;

    logic [31:0] rand_state = 32'h49e0_aa27;
    logic [31:0] model_regs [REG_COUNT];
    logic        model_sticky;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    jtag_dtm_top #(
        .DMI_ADDR_BITS (ADDR_BITS),
        .REG_COUNT     (REG_COUNT)
    ) jtag_dtm_top_inst (
        .rst_n      (rst_n),
        .jtag_TCK   (jtag_TCK),
        .jtag_tms_i (tms),
        .jtag_tdi_i (tdi),
        .jtag_tdo_o (tdo)
    );

    always #4 jtag_TCK = ~jtag_TCK;

    always @(posedge jtag_TCK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped, still not done after %0d cycles", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // idle hint in 14:12, dmistat 11:10, abits 9:4, version 3:0
    function automatic logic [31:0] dtmcs_expect(input logic [1:0] stat);
        return {17'b0, 3'd5, stat, 6'(ADDR_BITS), 4'd1};
    endfunction

    // what a DMI capture should hold for the model state
    function automatic logic [39:0] capture_expect(input logic [5:0] addr,
                                                   input logic [31:0] data);
        return model_sticky ? BUSY_WORD : {addr, data, RESP_OK};
    endfunction

    function automatic logic values_differ(input logic [39:0] expected,
                                           input logic [39:0] actual);
        check_count++;
        return expected !== actual;
    endfunction

    task automatic report_mismatch(input string name, input logic [39:0] expected,
                                   input logic [39:0] actual);
        error_count++;
        $display("Error %s: expected %h, actual %h", name, expected, actual);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic clock_bit(input logic tms_val, input logic tdi_val, output logic tdo_val);
        tms = tms_val;
        tdi = tdi_val;
        #6;
        tdo_val = tdo;  // settled since the falling edge
        @(posedge jtag_TCK);
        #1;
    endtask

    task automatic tap_reset();
        logic unused;
        repeat (5) clock_bit(1'b1, 1'b0, unused);
        clock_bit(1'b0, 1'b0, unused);
    endtask

    task automatic idle(input int cycles);
        logic unused;
        repeat (cycles) clock_bit(1'b0, 1'b0, unused);
    endtask

    task automatic shift_ir(input logic [4:0] code);
        logic unused;
        clock_bit(1'b1, 1'b0, unused);  // to SELECT_DR
        clock_bit(1'b1, 1'b0, unused);  // to SELECT_IR
        clock_bit(1'b0, 1'b0, unused);  // to CAPTURE_IR
        clock_bit(1'b0, 1'b0, unused);  // to SHIFT_IR
        for (int i = 0; i < 5; i++) begin
            clock_bit(i == 4, code[i], unused);
        end
        clock_bit(1'b1, 1'b0, unused);  // to UPDATE_IR
        clock_bit(1'b0, 1'b0, unused);
    endtask

    // lsb first in and out, ends back in RUN_TEST_IDLE
    task automatic shift_dr(input int nbits, input logic [39:0] din, output logic [39:0] dout);
        logic unused;
        logic bit_out;
        dout = '0;
        clock_bit(1'b1, 1'b0, unused);
        clock_bit(1'b0, 1'b0, unused);
        clock_bit(1'b0, 1'b0, unused);  // to SHIFT_DR
        for (int i = 0; i < nbits; i++) begin
            clock_bit(i == nbits - 1, din[i], bit_out);
            dout[i] = bit_out;
        end
        clock_bit(1'b1, 1'b0, unused);  // to UPDATE_DR
        clock_bit(1'b0, 1'b0, unused);
    endtask

    task automatic dmi_scan(input logic [1:0] op, input logic [5:0] addr,
                            input logic [31:0] data, output logic [39:0] captured);
        shift_dr(40, {addr, data, op}, captured);
    endtask

    // let the access finish, then pick up its response with a nop scan
    task automatic collect_result(output logic [39:0] captured);
        idle(10);
        dmi_scan(OP_NOP, '0, '0, captured);
        idle(10);
    endtask

    task automatic dmi_reset();
        logic [39:0] unused;
        shift_ir(IR_DTMCS);
        shift_dr(32, 40'h1_0000, unused);  // bit 16
        model_sticky = 1'b0;
        shift_ir(IR_DMI);
    endtask

    initial begin
        logic [39:0] dout;
        logic [39:0] expect_word;
        logic [31:0] pattern;
        logic [31:0] rnd;
        logic [31:0] wdata;
        logic [31:0] expect_data;
        logic [5:0]  addr;
        logic [1:0]  op;

        rst_n        = 1'b0;
        tms          = 1'b1;
        tdi          = 1'b0;
        model_sticky = 1'b0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge jtag_TCK);
        #1;
        rst_n = 1'b1;

        tap_reset();
        shift_dr(32, '0, dout);
        if (values_differ(40'h1e_200a_6f, dout)) report_mismatch("idcode", 40'h1e_200a_6f, dout);

        shift_ir(IR_BYPASS);
        pattern = next_random();
        shift_dr(32, {8'h0, pattern}, dout);
        if (values_differ({8'h0, pattern[30:0], 1'b0}, dout)) begin
            report_mismatch("bypass", {8'h0, pattern[30:0], 1'b0}, dout);
        end

        shift_ir(IR_DTMCS);
        shift_dr(32, '0, dout);
        if (values_differ({8'h0, dtmcs_expect(2'd0)}, dout)) begin
            report_mismatch("dtmcs", {8'h0, dtmcs_expect(2'd0)}, dout);
        end

        shift_ir(IR_DMI);
        repeat (60) begin
            addr  = 6'((next_random() >> 8) % 21);  // goes past REG_COUNT on purpose
            wdata = next_random();
            rnd   = next_random();
            op    = rnd[20] ? OP_WRITE : OP_READ;
            if (addr < REG_COUNT) begin
                expect_data = (op == OP_WRITE) ? wdata : model_regs[int'(addr)];
                if (op == OP_WRITE) model_regs[int'(addr)] = wdata;
            end else begin
                expect_data = '0;
            end
            dmi_scan(op, addr, wdata, dout);
            collect_result(dout);
            expect_word = capture_expect(addr, expect_data);
            if (values_differ(expect_word, dout)) report_mismatch("dmi access", expect_word, dout);
        end

        // capture again straight after a read while its response is still in flight
        addr = 6'((next_random() >> 8) % REG_COUNT);
        dmi_scan(OP_READ, addr, '0, dout);
        dmi_scan(OP_NOP, '0, '0, dout);
        model_sticky = 1'b1;
        if (values_differ(BUSY_WORD, dout)) report_mismatch("busy capture", BUSY_WORD, dout);
        collect_result(dout);
        expect_word = capture_expect(addr, model_regs[int'(addr)]);
        if (values_differ(expect_word, dout)) report_mismatch("sticky busy", expect_word, dout);
        shift_ir(IR_DTMCS);
        shift_dr(32, '0, dout);
        if (values_differ({8'h0, dtmcs_expect({1'b0, model_sticky})}, dout)) begin
            report_mismatch("dtmcs dmistat", {8'h0, dtmcs_expect({1'b0, model_sticky})}, dout);
        end
        dmi_reset();
        dmi_scan(OP_READ, addr, '0, dout);
        collect_result(dout);
        expect_word = capture_expect(addr, model_regs[int'(addr)]);
        if (values_differ(expect_word, dout)) begin
            report_mismatch("read after dmireset", expect_word, dout);
        end

        // write while sticky busy must be dropped
        addr  = 6'((next_random() >> 8) % REG_COUNT);
        wdata = next_random();
        dmi_scan(OP_READ, addr, '0, dout);
        dmi_scan(OP_NOP, '0, '0, dout);
        model_sticky = 1'b1;
        idle(10);
        dmi_scan(OP_WRITE, addr, wdata, dout);
        expect_word = capture_expect(addr, model_regs[int'(addr)]);
        if (values_differ(expect_word, dout)) report_mismatch("write while busy", expect_word, dout);
        idle(10);
        dmi_reset();
        dmi_scan(OP_READ, addr, '0, dout);
        collect_result(dout);
        expect_word = capture_expect(addr, model_regs[int'(addr)]);
        if (values_differ(expect_word, dout)) begin
            report_mismatch("dropped write", expect_word, dout);
        end

        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- jtag_dtm_top.f
src/dtm_pkg.sv
src/dmi_pkg.sv
src/jtag_tap_ctrl.sv
src/jtag_dtm.sv
src/dmi_req_tx.sv
src/dmi_resp_rx.sv
src/dmi_regfile.sv
src/jtag_dtm_top.sv
dv/tb_jtag_dtm_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_jtag_dtm_top -f jtag_dtm_top.f \
    -o sim_tb > sim.log 2>&1 && ./obj_dir/sim_tb >> sim.log 2>&1 || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
